//--- src/rv_exec_pkg.sv
// RV32I execution subsystem shared definitions
// Data and register index widths, opcode and funct3 encodings,
// ALU operations and the R, I and U views of an instruction word
package rv_exec_pkg;

  localparam int XLEN       = 32;
  localparam int REG_ADDR_W = 5;
  localparam int NUM_REGS   = 1 << REG_ADDR_W;
  localparam int SHAMT_W    = 5;

  // Major opcodes of which only the first four execute
  typedef enum logic [6:0] {
    REGREG  = 7'b0110011,
    IMMED   = 7'b0010011,
    LUI     = 7'b0110111,
    AUIPC   = 7'b0010111,
    LOAD    = 7'b0000011,
    STORE   = 7'b0100011,
    BRANCH  = 7'b1100011,
    JAL     = 7'b1101111,
    JALR    = 7'b1100111,
    SYSTEM  = 7'b1110011,
    MISCMEM = 7'b0001111
  } opcode_t;

  // Shared by the register and immediate forms
  typedef enum logic [2:0] {
    ADDSUB = 3'b000,
    SLL    = 3'b001,
    SLT    = 3'b010,
    SLTU   = 3'b011,
    XOR    = 3'b100,
    SR     = 3'b101,
    OR     = 3'b110,
    AND    = 3'b111
  } funct3_t;

  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_SLL  = 4'd2,
    ALU_SRL  = 4'd3,
    ALU_SRA  = 4'd4,
    ALU_AND  = 4'd5,
    ALU_OR   = 4'd6,
    ALU_XOR  = 4'd7,
    ALU_SLT  = 4'd8,
    ALU_SLTU = 4'd9
  } alu_op_t;

  typedef struct packed {
    logic [6:0]            funct7;
    logic [REG_ADDR_W-1:0] rs2;
    logic [REG_ADDR_W-1:0] rs1;
    funct3_t               funct3;
    logic [REG_ADDR_W-1:0] rd;
    opcode_t               opcode;
  } rtype_t;

  typedef struct packed {
    logic [11:0]           imm11_00;
    logic [REG_ADDR_W-1:0] rs1;
    funct3_t               funct3;
    logic [REG_ADDR_W-1:0] rd;
    opcode_t               opcode;
  } itype_t;

  typedef struct packed {
    logic [19:0]           imm31_12;
    logic [REG_ADDR_W-1:0] rd;
    opcode_t               opcode;
  } utype_t;

  // One instruction word, three ways to read it
  typedef union packed {
    rtype_t r;
    itype_t i;
    utype_t u;
  } instr_u;

endpackage

//--- src/control_unit.sv
// Instruction decoder
// Cracks an RV32I word into register indices, immediate, operand
// selects and ALU operation. Only register, immediate, LUI and AUIPC
// forms execute; everything else is flagged illegal.
module control_unit
  import rv_exec_pkg::*;
(
  input  logic [XLEN-1:0]       instr_i,
  output logic [REG_ADDR_W-1:0] rs1_o,
  output logic [REG_ADDR_W-1:0] rs2_o,
  output logic [REG_ADDR_W-1:0] rd_o,
  output logic [XLEN-1:0]       imm_o,
  output logic                  a_sel_o,
  output logic                  b_sel_o,
  output logic                  zero_a_o,
  output alu_op_t               alu_op_o,
  output logic                  wen_o,
  output logic                  illegal_o
);

  instr_u  word;
  opcode_t opcode;
  funct3_t funct3;

  assign word   = instr_u'(instr_i);
  assign opcode = word.r.opcode;
  assign funct3 = word.r.funct3;

  assign rs1_o = word.r.rs1;
  assign rs2_o = word.r.rs2;
  assign rd_o  = word.r.rd;

  // I-type sign extended, U-type placed in the upper bits
  always_comb begin
    case (opcode)
      LUI, AUIPC: imm_o = {word.u.imm31_12, 12'b0};
      default:    imm_o = {{(XLEN-12){word.i.imm11_00[11]}}, word.i.imm11_00};
    endcase
  end

  // Operand A is the pc for AUIPC and zero for LUI
  assign a_sel_o  = (opcode == AUIPC);
  assign zero_a_o = (opcode == LUI);
  assign b_sel_o  = (opcode == IMMED) || (opcode == LUI) || (opcode == AUIPC);

  always_comb begin
    alu_op_o = ALU_ADD;
    if (opcode == REGREG || opcode == IMMED) begin
      case (funct3)
        ADDSUB: alu_op_o = (opcode == REGREG && instr_i[30]) ? ALU_SUB : ALU_ADD;
        SLL:    alu_op_o = ALU_SLL;
        SLT:    alu_op_o = ALU_SLT;
        SLTU:   alu_op_o = ALU_SLTU;
        XOR:    alu_op_o = ALU_XOR;
        // Bit 30 picks arithmetic shift in both forms
        SR:     alu_op_o = instr_i[30] ? ALU_SRA : ALU_SRL;
        OR:     alu_op_o = ALU_OR;
        AND:    alu_op_o = ALU_AND;
        default: alu_op_o = ALU_ADD;
      endcase
    end
  end

  // Register write for the executed classes
  always_comb begin
    case (opcode)
      REGREG:            wen_o = ~word.r.funct7[0];
      IMMED, LUI, AUIPC: wen_o = 1'b1;
      default:           wen_o = 1'b0;
    endcase
  end

  // M extension and every non-executed opcode
  always_comb begin
    case (opcode)
      REGREG:            illegal_o = word.r.funct7[0];
      IMMED, LUI, AUIPC: illegal_o = 1'b0;
      default:           illegal_o = 1'b1;
    endcase
  end

endmodule

//--- src/rv32i_reg_file.sv
// Integer register file
// 32 x 32 bits, two combinational read ports and one write port,
// x0 always reads zero
module rv32i_reg_file
  import rv_exec_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic [REG_ADDR_W-1:0] raddr1_i,
  input  logic [REG_ADDR_W-1:0] raddr2_i,
  output logic [XLEN-1:0]       rdata1_o,
  output logic [XLEN-1:0]       rdata2_o,
  input  logic                  we_i,
  input  logic [REG_ADDR_W-1:0] waddr_i,
  input  logic [XLEN-1:0]       wdata_i
);

  logic [XLEN-1:0] regs [NUM_REGS];

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we_i && waddr_i != '0) begin
      regs[waddr_i] <= wdata_i;
    end
  end

  // Reads return the old value during a same-cycle write
  assign rdata1_o = (raddr1_i == '0) ? '0 : regs[raddr1_i];
  assign rdata2_o = (raddr2_i == '0) ? '0 : regs[raddr2_i];

endmodule

//--- src/alu.sv
// Integer ALU
// Combinational RV32I arithmetic, logic, shift and compare
module alu
  import rv_exec_pkg::*;
(
  input  logic [XLEN-1:0] a_i,
  input  logic [XLEN-1:0] b_i,
  input  alu_op_t         op_i,
  output logic [XLEN-1:0] result_o
);

  logic [SHAMT_W-1:0] shamt;
  logic               lt_signed;
  logic               lt_unsigned;

  assign shamt       = b_i[SHAMT_W-1:0];
  assign lt_signed   = $signed(a_i) < $signed(b_i);
  assign lt_unsigned = a_i < b_i;

  always_comb begin
    case (op_i)
      ALU_ADD:  result_o = a_i + b_i;
      ALU_SUB:  result_o = a_i - b_i;
      ALU_SLL:  result_o = a_i << shamt;
      ALU_SRL:  result_o = a_i >> shamt;
      ALU_SRA:  result_o = $unsigned($signed(a_i) >>> shamt);
      ALU_AND:  result_o = a_i & b_i;
      ALU_OR:   result_o = a_i | b_i;
      ALU_XOR:  result_o = a_i ^ b_i;
      // Compares give 0 or 1
      ALU_SLT:  result_o = {{(XLEN-1){1'b0}}, lt_signed};
      ALU_SLTU: result_o = {{(XLEN-1){1'b0}}, lt_unsigned};
      default:  result_o = '0;
    endcase
  end

endmodule

//--- src/issue_stage.sv
// Issue stage
// Accepts decoded instructions, reads operands with forwarding from
// stage 1 and stage 2, selects ALU inputs and holds them for one cycle
module issue_stage
  import rv_exec_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  in_valid_i,
  output logic                  in_ready_o,
  input  logic [XLEN-1:0]       pc_i,
  input  logic [REG_ADDR_W-1:0] rs1_i,
  input  logic [REG_ADDR_W-1:0] rs2_i,
  input  logic [REG_ADDR_W-1:0] rd_i,
  input  logic [XLEN-1:0]       imm_i,
  input  logic                  a_sel_i,
  input  logic                  b_sel_i,
  input  logic                  zero_a_i,
  input  alu_op_t               alu_op_i,
  input  logic                  wen_i,
  input  logic                  illegal_i,
  output logic [REG_ADDR_W-1:0] rf_raddr1_o,
  output logic [REG_ADDR_W-1:0] rf_raddr2_o,
  input  logic [XLEN-1:0]       rf_rdata1_i,
  input  logic [XLEN-1:0]       rf_rdata2_i,
  input  logic [XLEN-1:0]       s1_result_i,
  input  logic [REG_ADDR_W-1:0] s2_rd_i,
  input  logic                  s2_wen_i,
  input  logic [XLEN-1:0]       s2_data_i,
  input  logic                  s2_valid_i,
  input  logic                  s2_ready_i,
  output logic                  s1_valid_o,
  output logic [XLEN-1:0]       op_a_o,
  output logic [XLEN-1:0]       op_b_o,
  output alu_op_t               alu_op_o,
  output logic [REG_ADDR_W-1:0] rd_o,
  output logic                  wen_o,
  output logic                  illegal_o,
  output logic [XLEN-1:0]       pc_o
);

  logic            s1_fwd_ok;
  logic            s2_fwd_ok;
  logic [XLEN-1:0] rs1_val;
  logic [XLEN-1:0] rs2_val;
  logic [XLEN-1:0] op_a_next;
  logic [XLEN-1:0] op_b_next;
  logic            accept;

  // Newest pending write wins and x0 never forwards
  function automatic logic [XLEN-1:0] forward(
    input logic [REG_ADDR_W-1:0] rs,
    input logic [XLEN-1:0]       rf_val,
    input logic                  s1_ok,
    input logic [REG_ADDR_W-1:0] s1_rd,
    input logic [XLEN-1:0]       s1_val,
    input logic                  s2_ok,
    input logic [REG_ADDR_W-1:0] s2_rd,
    input logic [XLEN-1:0]       s2_val
  );
    if (rs != '0 && s1_ok && rs == s1_rd) begin
      return s1_val;
    end else if (rs != '0 && s2_ok && rs == s2_rd) begin
      return s2_val;
    end
    return rf_val;
  endfunction

  assign rf_raddr1_o = rs1_i;
  assign rf_raddr2_o = rs2_i;

  assign s1_fwd_ok = s1_valid_o && wen_o;
  assign s2_fwd_ok = s2_valid_i && s2_wen_i;

  assign rs1_val = forward(rs1_i, rf_rdata1_i, s1_fwd_ok, rd_o, s1_result_i,
                           s2_fwd_ok, s2_rd_i, s2_data_i);
  assign rs2_val = forward(rs2_i, rf_rdata2_i, s1_fwd_ok, rd_o, s1_result_i,
                           s2_fwd_ok, s2_rd_i, s2_data_i);

  assign op_a_next = zero_a_i ? '0 : (a_sel_i ? pc_i : rs1_val);
  assign op_b_next = b_sel_i ? imm_i : rs2_val;

  // Free slot or the held item moves on this edge
  assign in_ready_o = !s1_valid_o || s2_ready_i;
  assign accept     = in_valid_i && in_ready_o;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      s1_valid_o <= 1'b0;
    end else if (in_ready_o) begin
      s1_valid_o <= in_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      op_a_o    <= op_a_next;
      op_b_o    <= op_b_next;
      alu_op_o  <= alu_op_i;
      rd_o      <= rd_i;
      wen_o     <= wen_i;
      illegal_o <= illegal_i;
      pc_o      <= pc_i;
    end
  end

  property p_s1_hold;
    @(posedge clk_i) disable iff (!rst_n_i)
      (s1_valid_o && !s2_ready_i) |=> (s1_valid_o && $stable(op_a_o) && $stable(op_b_o)
        && $stable(alu_op_o) && $stable(rd_o) && $stable(wen_o) && $stable(illegal_o)
        && $stable(pc_o));
  endproperty

  a_s1_hold: assert property (p_s1_hold)
    else $error("issue_stage: stage-1 contents changed while stalled");

endmodule

//--- src/writeback_stage.sv
// Writeback stage
// Holds one result, offers it on the output stream and commits it to
// the register file on the edge that the output is accepted
module writeback_stage
  import rv_exec_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  s1_valid_i,
  output logic                  s2_ready_o,
  input  logic [XLEN-1:0]       result_i,
  input  logic [REG_ADDR_W-1:0] rd_i,
  input  logic                  wen_i,
  input  logic                  illegal_i,
  input  logic [XLEN-1:0]       pc_i,
  output logic                  out_valid_o,
  input  logic                  out_ready_i,
  output logic [REG_ADDR_W-1:0] out_rd_o,
  output logic [XLEN-1:0]       out_data_o,
  output logic [XLEN-1:0]       out_pc_o,
  output logic                  out_illegal_o,
  output logic                  rf_we_o,
  output logic [REG_ADDR_W-1:0] rf_waddr_o,
  output logic [XLEN-1:0]       rf_wdata_o,
  output logic [REG_ADDR_W-1:0] s2_rd_o,
  output logic                  s2_wen_o,
  output logic [XLEN-1:0]       s2_data_o
);

  logic wen_q;

  assign s2_ready_o = !out_valid_o || out_ready_i;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      out_valid_o <= 1'b0;
    end else if (s2_ready_o) begin
      out_valid_o <= s1_valid_i;
    end
  end

  // Illegal instructions report zero and never write
  always_ff @(posedge clk_i) begin
    if (s1_valid_i && s2_ready_o) begin
      out_rd_o      <= rd_i;
      out_data_o    <= illegal_i ? '0 : result_i;
      out_pc_o      <= pc_i;
      out_illegal_o <= illegal_i;
      wen_q         <= wen_i && !illegal_i;
    end
  end

  assign rf_we_o    = out_valid_o && out_ready_i && wen_q;
  assign rf_waddr_o = out_rd_o;
  assign rf_wdata_o = out_data_o;

  assign s2_rd_o   = out_rd_o;
  assign s2_wen_o  = wen_q;
  assign s2_data_o = out_data_o;

  property p_out_hold;
    @(posedge clk_i) disable iff (!rst_n_i)
      (out_valid_o && !out_ready_i) |=> (out_valid_o && $stable(out_data_o)
        && $stable(out_rd_o) && $stable(out_pc_o) && $stable(out_illegal_o));
  endproperty

  a_out_hold: assert property (p_out_hold)
    else $error("writeback_stage: output dropped or changed before acceptance");

endmodule

//--- src/rv_exec_top.sv
// RV32I execution subsystem
// Decoder, issue stage, ALU, writeback stage and register file in a
// two-stage valid/ready pipeline
module rv_exec_top
  import rv_exec_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  in_valid_i,
  output logic                  in_ready_o,
  input  logic [XLEN-1:0]       in_instr_i,
  input  logic [XLEN-1:0]       in_pc_i,
  output logic                  out_valid_o,
  input  logic                  out_ready_i,
  output logic [REG_ADDR_W-1:0] out_rd_o,
  output logic [XLEN-1:0]       out_data_o,
  output logic [XLEN-1:0]       out_pc_o,
  output logic                  out_illegal_o
);

  // Decoded fields
  logic [REG_ADDR_W-1:0] dec_rs1;
  logic [REG_ADDR_W-1:0] dec_rs2;
  logic [REG_ADDR_W-1:0] dec_rd;
  logic [XLEN-1:0]       dec_imm;
  logic                  dec_a_sel;
  logic                  dec_b_sel;
  logic                  dec_zero_a;
  alu_op_t               dec_alu_op;
  logic                  dec_wen;
  logic                  dec_illegal;

  // Register file ports
  logic [REG_ADDR_W-1:0] rf_raddr1;
  logic [REG_ADDR_W-1:0] rf_raddr2;
  logic [XLEN-1:0]       rf_rdata1;
  logic [XLEN-1:0]       rf_rdata2;
  logic                  rf_we;
  logic [REG_ADDR_W-1:0] rf_waddr;
  logic [XLEN-1:0]       rf_wdata;

  // Stage 1 contents and stage 2 feedback
  logic                  s1_valid;
  logic [XLEN-1:0]       s1_op_a;
  logic [XLEN-1:0]       s1_op_b;
  alu_op_t               s1_alu_op;
  logic [REG_ADDR_W-1:0] s1_rd;
  logic                  s1_wen;
  logic                  s1_illegal;
  logic [XLEN-1:0]       s1_pc;
  logic [XLEN-1:0]       alu_result;
  logic                  s2_ready;
  logic [REG_ADDR_W-1:0] s2_rd;
  logic                  s2_wen;
  logic [XLEN-1:0]       s2_data;

  control_unit i_control_unit (
    .instr_i(in_instr_i), .rs1_o(dec_rs1), .rs2_o(dec_rs2), .rd_o(dec_rd),
    .imm_o(dec_imm), .a_sel_o(dec_a_sel), .b_sel_o(dec_b_sel), .zero_a_o(dec_zero_a),
    .alu_op_o(dec_alu_op), .wen_o(dec_wen), .illegal_o(dec_illegal)
  );

  issue_stage i_issue_stage (
    .clk_i(clk_i), .rst_n_i(rst_n_i), .in_valid_i(in_valid_i), .in_ready_o(in_ready_o),
    .pc_i(in_pc_i), .rs1_i(dec_rs1), .rs2_i(dec_rs2), .rd_i(dec_rd), .imm_i(dec_imm),
    .a_sel_i(dec_a_sel), .b_sel_i(dec_b_sel), .zero_a_i(dec_zero_a),
    .alu_op_i(dec_alu_op), .wen_i(dec_wen), .illegal_i(dec_illegal),
    .rf_raddr1_o(rf_raddr1), .rf_raddr2_o(rf_raddr2),
    .rf_rdata1_i(rf_rdata1), .rf_rdata2_i(rf_rdata2), .s1_result_i(alu_result),
    .s2_rd_i(s2_rd), .s2_wen_i(s2_wen), .s2_data_i(s2_data),
    .s2_valid_i(out_valid_o), .s2_ready_i(s2_ready),
    .s1_valid_o(s1_valid), .op_a_o(s1_op_a), .op_b_o(s1_op_b), .alu_op_o(s1_alu_op),
    .rd_o(s1_rd), .wen_o(s1_wen), .illegal_o(s1_illegal), .pc_o(s1_pc)
  );

  alu i_alu (
    .a_i(s1_op_a), .b_i(s1_op_b), .op_i(s1_alu_op), .result_o(alu_result)
  );

  writeback_stage i_writeback_stage (
    .clk_i(clk_i), .rst_n_i(rst_n_i), .s1_valid_i(s1_valid), .s2_ready_o(s2_ready),
    .result_i(alu_result), .rd_i(s1_rd), .wen_i(s1_wen), .illegal_i(s1_illegal),
    .pc_i(s1_pc), .out_valid_o(out_valid_o), .out_ready_i(out_ready_i),
    .out_rd_o(out_rd_o), .out_data_o(out_data_o), .out_pc_o(out_pc_o),
    .out_illegal_o(out_illegal_o), .rf_we_o(rf_we), .rf_waddr_o(rf_waddr),
    .rf_wdata_o(rf_wdata), .s2_rd_o(s2_rd), .s2_wen_o(s2_wen), .s2_data_o(s2_data)
  );

  rv32i_reg_file i_rv32i_reg_file (
    .clk_i(clk_i), .rst_n_i(rst_n_i), .raddr1_i(rf_raddr1), .raddr2_i(rf_raddr2),
    .rdata1_o(rf_rdata1), .rdata2_o(rf_rdata2), .we_i(rf_we), .waddr_i(rf_waddr),
    .wdata_i(rf_wdata)
  );

endmodule

//--- verif/tb_rv_exec_top.sv
// Testbench for the RV32I execution subsystem
// Streams instructions with random output stalls, predicts every result
// with a reference model and checks the output stream with assertions
module tb_rv_exec_top
  import rv_exec_pkg::*;
();

  localparam int TIMEOUT = 50;

  typedef struct packed {
    logic        illegal;
    logic [4:0]  rd;
    logic [31:0] pc;
    logic [31:0] data;
  } exp_t;

  logic        clk_i = 1'b0;
  logic        rst_n_i;
  logic        in_valid_i;
  logic        in_ready_o;
  logic [31:0] in_instr_i;
  logic [31:0] in_pc_i;
  logic        out_valid_o;
  logic        out_ready_i = 1'b1;
  logic [4:0]  out_rd_o;
  logic [31:0] out_data_o;
  logic [31:0] out_pc_o;
  logic        out_illegal_o;

  integer      seed = 3630;
  int          errors = 0;
  int          checks = 0;
  int          tests_run = 0;
  int          tests_failed = 0;
  int          test_start_errs = 0;
  logic        hung = 1'b0;
  logic        stall_mode = 1'b0;
  logic        lat_check = 1'b0;
  logic [31:0] next_pc = 32'h100;

  // Reference state updated in program order at input acceptance
  logic [31:0] model_regs [32];
  exp_t        exp_q [$];
  logic        exp_valid = 1'b0;
  logic [4:0]  exp_rd;
  logic [31:0] exp_data;
  logic [31:0] exp_pc;
  logic        exp_illegal;
  logic        in_fire;
  logic        out_fire;
  logic [1:0]  lat_v;
  logic [31:0] lat_pc1;
  logic [31:0] lat_pc2;

  rv_exec_top i_rv_exec_top (.*);

  always #5 clk_i = ~clk_i;

  // Output back-pressure that is random only while stalls are wanted
  always @(posedge clk_i) begin
    #1;
    if (stall_mode) begin
      out_ready_i = 1'($random(seed));
    end else begin
      out_ready_i = 1'b1;
    end
  end

  assign in_fire  = in_valid_i && in_ready_o;
  assign out_fire = out_valid_o && out_ready_i;

  function automatic logic [31:0] expected_alu(input logic [2:0] f3, input logic alt,
                                               input logic [31:0] a, input logic [31:0] b);
    logic [31:0] r;
    case (f3)
      3'd0: r = alt ? a - b : a + b;
      3'd1: r = a << b[4:0];
      3'd2: r = {31'b0, $signed(a) < $signed(b)};
      3'd3: r = {31'b0, a < b};
      3'd4: r = a ^ b;
      3'd5: begin
        if (alt) begin
          r = $signed(a) >>> b[4:0];
        end else begin
          r = a >> b[4:0];
        end
      end
      3'd6: r = a | b;
      default: r = a & b;
    endcase
    return r;
  endfunction

  function automatic logic [31:0] reference_result(input logic [31:0] instr,
                                                   input logic [31:0] pc, output logic illegal);
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm_i;
    logic [31:0] imm_u;
    logic [31:0] res;
    a       = model_regs[instr[19:15]];
    b       = model_regs[instr[24:20]];
    imm_i   = {{20{instr[31]}}, instr[31:20]};
    imm_u   = {instr[31:12], 12'h000};
    illegal = 1'b0;
    res     = '0;
    case (instr[6:0])
      7'h33: begin
        // funct7 bit 0 marks the M extension
        illegal = instr[25];
        res     = instr[25] ? '0 : expected_alu(instr[14:12], instr[30], a, b);
      end
      7'h13: res = expected_alu(instr[14:12], instr[30] && instr[14:12] == 3'd5, a, imm_i);
      7'h37: res = imm_u;
      7'h17: res = pc + imm_u;
      default: illegal = 1'b1;
    endcase
    return res;
  endfunction

  // Expected results queue and latency history
  always @(posedge clk_i) begin
    exp_t        entry;
    logic        ill;
    logic [31:0] res;
    if (!rst_n_i) begin
      for (int k = 0; k < 32; k++) begin
        model_regs[k] = '0;
      end
      exp_q.delete();
      lat_v <= 2'b00;
    end else begin
      if (out_fire) begin
        checks++;
        if (exp_q.size() != 0) begin
          void'(exp_q.pop_front());
        end
      end
      if (in_fire) begin
        res           = reference_result(in_instr_i, in_pc_i, ill);
        entry.illegal = ill;
        entry.rd      = in_instr_i[11:7];
        entry.pc      = in_pc_i;
        entry.data    = res;
        exp_q.push_back(entry);
        if (!ill && in_instr_i[11:7] != 5'd0) begin
          model_regs[in_instr_i[11:7]] = res;
        end
      end
      lat_v <= {lat_v[0], in_fire && lat_check};
    end
    exp_valid <= (exp_q.size() != 0);
    if (exp_q.size() != 0) begin
      exp_rd      <= exp_q[0].rd;
      exp_data    <= exp_q[0].data;
      exp_pc      <= exp_q[0].pc;
      exp_illegal <= exp_q[0].illegal;
    end
    lat_pc1 <= in_pc_i;
    lat_pc2 <= lat_pc1;
  end

  a_reset_state: assert property (@(posedge clk_i) $rose(rst_n_i) |-> in_ready_o && !out_valid_o)
    else begin
      errors++;
      $display("error at %0t: after reset in_ready_o is %b, out_valid_o is %b",
               $time, $sampled(in_ready_o), $sampled(out_valid_o));
    end

  a_known: assert property (@(posedge clk_i) disable iff (!rst_n_i) out_fire |-> exp_valid)
    else begin
      errors++;
      $display("at %0t an output was accepted with no instruction outstanding", $time);
    end

  a_rd: assert property (@(posedge clk_i) disable iff (!rst_n_i) out_fire |-> out_rd_o == exp_rd)
    else begin
      errors++;
      $display("error at %0t: out_rd_o is %0d, expected %0d", $time, $sampled(out_rd_o),
               $sampled(exp_rd));
    end

  a_data: assert property (@(posedge clk_i) disable iff (!rst_n_i)
                           out_fire |-> out_data_o == exp_data)
    else begin
      errors++;
      $display("error at %0t: out_data_o is %h, expected %h", $time, $sampled(out_data_o),
               $sampled(exp_data));
    end

  a_pc: assert property (@(posedge clk_i) disable iff (!rst_n_i) out_fire |-> out_pc_o == exp_pc)
    else begin
      errors++;
      $display("error at %0t: out_pc_o is %h, expected %h", $time, $sampled(out_pc_o),
               $sampled(exp_pc));
    end

  a_illegal: assert property (@(posedge clk_i) disable iff (!rst_n_i)
                              out_fire |-> out_illegal_o == exp_illegal)
    else begin
      errors++;
      $display("error at %0t: out_illegal_o is %b, expected %b", $time,
               $sampled(out_illegal_o), $sampled(exp_illegal));
    end

  // Two edges from input acceptance to output acceptance
  a_latency: assert property (@(posedge clk_i) disable iff (!rst_n_i)
                              lat_v[1] |-> out_valid_o && out_pc_o == lat_pc2)
    else begin
      errors++;
      $display("error at %0t: out_pc_o is %h (valid %b), expected %h two cycles after accept",
               $time, $sampled(out_pc_o), $sampled(out_valid_o), $sampled(lat_pc2));
    end

  function automatic logic [31:0] rtype_word(input logic [6:0] f7, input logic [4:0] rs2,
                                             input logic [4:0] rs1, input logic [2:0] f3,
                                             input logic [4:0] rd);
    instr_u w;
    w.r.funct7 = f7;
    w.r.rs2    = rs2;
    w.r.rs1    = rs1;
    w.r.funct3 = funct3_t'(f3);
    w.r.rd     = rd;
    w.r.opcode = REGREG;
    return w;
  endfunction

  function automatic logic [31:0] itype_word(input logic [11:0] imm, input logic [4:0] rs1,
                                             input logic [2:0] f3, input logic [4:0] rd,
                                             input opcode_t op);
    instr_u w;
    w.i.imm11_00 = imm;
    w.i.rs1      = rs1;
    w.i.funct3   = funct3_t'(f3);
    w.i.rd       = rd;
    w.i.opcode   = op;
    return w;
  endfunction

  function automatic logic [31:0] utype_word(input logic [19:0] imm, input logic [4:0] rd,
                                             input opcode_t op);
    instr_u w;
    w.u.imm31_12 = imm;
    w.u.rd       = rd;
    w.u.opcode   = op;
    return w;
  endfunction

  // Holds the instruction until the DUT takes it
  task automatic send(input logic [31:0] instr);
    int waited;
    waited = 0;
    if (hung) begin
      return;
    end
    in_valid_i = 1'b1;
    in_instr_i = instr;
    in_pc_i    = next_pc;
    @(negedge clk_i);
    while (!in_ready_o && waited < TIMEOUT) begin
      @(negedge clk_i);
      waited++;
    end
    if (!in_ready_o) begin
      $display("timeout: instruction at pc %h was never accepted", next_pc);
      hung = 1'b1;
    end
    @(posedge clk_i);
    #1;
    next_pc = next_pc + 32'd4;
  endtask

  task automatic drain();
    int waited;
    waited     = 0;
    in_valid_i = 1'b0;
    while (exp_q.size() != 0 && waited < 4 * TIMEOUT && !hung) begin
      @(posedge clk_i);
      #1;
      waited++;
    end
    if (exp_q.size() != 0 && !hung) begin
      $display("timeout: %0d results never came out", exp_q.size());
      hung = 1'b1;
    end
  endtask

  task automatic send_alu_r(input int idx, input logic [4:0] rd, input logic [4:0] rs1,
                            input logic [4:0] rs2);
    logic [6:0] f7;
    logic [2:0] f3;
    case (idx)
      0: {f7, f3} = {7'h00, 3'd0};
      1: {f7, f3} = {7'h20, 3'd0};
      2: {f7, f3} = {7'h00, 3'd1};
      3: {f7, f3} = {7'h00, 3'd2};
      4: {f7, f3} = {7'h00, 3'd3};
      5: {f7, f3} = {7'h00, 3'd4};
      6: {f7, f3} = {7'h00, 3'd5};
      7: {f7, f3} = {7'h20, 3'd5};
      8: {f7, f3} = {7'h00, 3'd6};
      default: {f7, f3} = {7'h00, 3'd7};
    endcase
    send(rtype_word(f7, rs2, rs1, f3, rd));
  endtask

  // Shift forms carry shamt and the arithmetic bit in the immediate
  task automatic send_alu_i(input logic [2:0] f3, input logic alt, input logic [11:0] imm,
                            input logic [4:0] rd, input logic [4:0] rs1);
    logic [11:0] field;
    field = imm;
    if (f3 == 3'd1) begin
      field = {7'b0, imm[4:0]};
    end else if (f3 == 3'd5) begin
      field = {1'b0, alt, 5'b0, imm[4:0]};
    end
    send(itype_word(field, rs1, f3, rd, IMMED));
  endtask

  task automatic load_reg(input logic [4:0] rd, input logic [31:0] value);
    send(utype_word(value[31:12] + {19'b0, value[11]}, rd, LUI));
    send(itype_word(value[11:0], rd, 3'd0, rd, IMMED));
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (errors != test_start_errs || hung) begin
      tests_failed++;
      $display("test %0d %s: failed", tests_run, name);
    end else begin
      $display("test %0d %s: ok", tests_run, name);
    end
    test_start_errs = errors;
  endtask

  initial begin
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [2:0]  f3;
    logic [31:0] value;
    rst_n_i    = 1'b0;
    in_valid_i = 1'b0;
    in_instr_i = '0;
    in_pc_i    = '0;
    repeat (2) @(posedge clk_i);
    #1;
    rst_n_i = 1'b1;

    // Every register through or x0, xk, x0
    for (int k = 0; k < 32; k++) begin
      send(rtype_word(7'h00, 5'd0, 5'(k), 3'd6, 5'd0));
    end
    drain();
    end_test("reset state");

    for (int round = 0; round < 4; round++) begin
      if (round == 0) begin
        load_reg(5'd1, 32'hffff_fff0);
        load_reg(5'd2, 32'd5);
      end else begin
        load_reg(5'd1, $random(seed));
        load_reg(5'd2, $random(seed));
      end
      for (int op = 0; op < 10; op++) begin
        send_alu_r(op, 5'(3 + op), 5'd1, 5'd2);
      end
    end
    drain();
    end_test("register-register ops");

    for (int round = 0; round < 4; round++) begin
      value = (round == 0) ? 32'h8000_1234 : $random(seed);
      load_reg(5'd1, value);
      for (int f = 0; f < 8; f++) begin
        send_alu_i(3'(f), 1'b0, 12'($random(seed)), 5'(10 + f), 5'd1);
      end
      send_alu_i(3'd5, 1'b1, 12'($random(seed)), 5'd18, 5'd1);
      send_alu_i(3'd3, 1'b0, 12'h800 | 12'($random(seed)), 5'd19, 5'd1);
      send_alu_i(3'd2, 1'b0, 12'h800 | 12'($random(seed)), 5'd20, 5'd1);
    end
    drain();
    end_test("register-immediate ops");

    for (int n = 0; n < 6; n++) begin
      next_pc = {$random(seed)} & 32'hffff_fffc;
      send(utype_word(20'($random(seed)), 5'(21 + n), LUI));
      next_pc = {$random(seed)} & 32'hffff_fffc;
      send(utype_word(20'($random(seed)), 5'(21 + n), AUIPC));
    end
    drain();
    end_test("lui and auipc");

    // Short register set keeps the chain dependent
    stall_mode = 1'b1;
    for (int n = 0; n < 48; n++) begin
      rd  = 5'(1 + {$random(seed)} % 4);
      rs1 = 5'(1 + {$random(seed)} % 4);
      rs2 = 5'(1 + {$random(seed)} % 4);
      if (1'($random(seed))) begin
        send_alu_r({$random(seed)} % 10, rd, rs1, rs2);
      end else begin
        f3 = 3'($random(seed));
        send_alu_i(f3, 1'($random(seed)), 12'($random(seed)), rd, rs1);
      end
    end
    drain();
    stall_mode = 1'b0;
    @(posedge clk_i);
    #1;
    lat_check = 1'b1;
    for (int n = 0; n < 10; n++) begin
      send_alu_i(3'd0, 1'b0, 12'(n + 1), 5'd1, 5'd1);
      send_alu_r(0, 5'd2, 5'd2, 5'd1);
    end
    drain();
    lat_check = 1'b0;
    end_test("dependent chains");

    load_reg(5'd7, 32'h1234_5678);
    load_reg(5'd1, 32'd40);
    send({20'h00000, 5'd7, 7'h7f});
    send(itype_word(12'h000, 5'd1, 3'd2, 5'd7, LOAD));
    send(rtype_word(7'h01, 5'd1, 5'd1, 3'd0, 5'd7));
    send(itype_word(12'h000, 5'd7, 3'd0, 5'd8, IMMED));
    send(itype_word(12'h055, 5'd1, 3'd0, 5'd0, IMMED));
    send(rtype_word(7'h00, 5'd0, 5'd0, 3'd0, 5'd9));
    send(itype_word(12'h001, 5'd0, 3'd0, 5'd10, IMMED));
    drain();
    end_test("illegal and x0");

    $display("%0d tests, %0d failed, %0d outputs checked, %0d errors",
             tests_run, tests_failed, checks, errors);
    if (errors == 0 && tests_failed == 0 && !hung) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

//--- src.f
src/rv_exec_pkg.sv
src/control_unit.sv
src/rv32i_reg_file.sv
src/alu.sv
src/issue_stage.sv
src/writeback_stage.sv
src/rv_exec_top.sv
verif/tb_rv_exec_top.sv

//--- Makefile
# Verilator build and run of the RV32I execution subsystem testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_rv_exec_top
FILELIST  := src.f
OBJDIR    := obj_dir
LOG       := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"

$(OBJDIR)/V$(TOP): $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

test: $(OBJDIR)/V$(TOP)
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	@grep -q -F '** PASS **' $(LOG) || (echo "simulation failed"; exit 1)

clean:
	rm -rf $(OBJDIR) $(LOG)
